//--- common/sata_prim_pkg.sv
// primitive values are Gen1/2/3 dword-mode; byte 0 is the first byte on the wire and carries K28.x
`default_nettype none

package sata_prim_pkg;

    // ------------------------------
    // dword as the transceiver sees it
    // ------------------------------
    typedef struct packed {
        logic [31:0] data;   // four bytes, byte 0 in [7:0]
        logic [3:0]  datak;  // one k-flag per byte
    } sata_dword_t;          // 36 bits

    // k-flag patterns
    localparam logic [3:0] DWORD_IS_PRIM = 4'b0001;  // K28.x in byte 0 only
    localparam logic [3:0] DWORD_IS_DATA = 4'b0000;

    // ------------------------------
    // primitives
    // ------------------------------
    // ALIGN, K28.5 D10.2 D10.2 D27.3
    localparam sata_dword_t ALIGN_DWORD = '{data: 32'h7B4A_4ABC, datak: DWORD_IS_PRIM};

    // SYNC, K28.3 D21.4 D21.5 D21.5
    localparam sata_dword_t SYNC_DWORD = '{data: 32'hB5B5_957C, datak: DWORD_IS_PRIM};

    // D10.2 dial tone, sent while the device hunts for ALIGN
    localparam sata_dword_t DIAL_DWORD = '{data: 32'h4A4A_4A4A, datak: DWORD_IS_DATA};

    // value of the tx register under reset
    localparam sata_dword_t IDLE_DWORD = '{data: 32'h0000_0000, datak: DWORD_IS_DATA};

endpackage : sata_prim_pkg

`default_nettype wire

//--- common/sata_link_pkg.sv
// default timing values assume Gen1 at 37.5 MHz; the state encoding doubles as the command decode
`default_nettype none

package sata_link_pkg;

    // ------------------------------
    // state encoding bits
    // ------------------------------
    localparam int unsigned BIT_LINK_READY  = 0;  // link up, user data allowed
    localparam int unsigned BIT_COMRESET    = 1;  // comreset command pulse
    localparam int unsigned BIT_COMWAKE     = 2;  // comwake command pulse
    localparam int unsigned BIT_OOB_FINISH  = 3;  // oob phase over, level
    localparam int unsigned BIT_DIAL_SEL    = 4;  // send D10.2
    localparam int unsigned BIT_TIMEOUT_RUN = 5;  // waiting, timeout counter runs
    // bits 7:6 only tell apart states with equal low bits

    typedef enum logic [7:0] {
        st_idle             = 8'b00_0_0_0_0_0_0,
        st_send_comreset    = 8'b00_0_0_0_0_1_0,
        st_suspend_comreset = 8'b01_0_0_0_0_0_0,
        st_wait_cominit     = 8'b00_1_0_0_0_0_0,
        st_send_comwake     = 8'b00_0_0_0_1_0_0,
        st_suspend_comwake  = 8'b10_0_0_0_0_0_0,
        st_wait_comwake     = 8'b01_1_0_0_0_0_0,
        st_wait_oobfinish   = 8'b10_1_0_1_0_0_0,
        st_send_dial        = 8'b11_1_1_1_0_0_0,
        st_send_align       = 8'b11_1_0_1_0_0_0,
        st_link_ready       = 8'b11_0_0_0_0_0_1
    } link_state_t;

    // ------------------------------
    // grouped status and command
    // ------------------------------
    typedef struct packed {
        logic       signal_detect;  // squelch open
        logic       locked_to_ref;  // cdr locked to reference clock
        logic       cominit;        // one-cycle pulse from oob decoder
        logic       comwake;        // one-cycle pulse from oob decoder
        logic       oob_finish;     // level, device done with oob
        logic [3:0] sync_status;    // per-byte word-sync flags
    } rx_status_t;

    typedef struct packed {
        logic comreset;    // pulse
        logic comwake;     // pulse
        logic oob_finish;  // level
    } oob_cmd_t;

    // ------------------------------
    // default timing, tx_reset cycles
    // ------------------------------
    localparam int unsigned DEF_TIMEOUT_CYCLES = 33000;  // 880 us at 37.5 MHz
    localparam int unsigned DEF_ALIGN_INTERVAL = 256;    // dwords between ALIGN pairs
    localparam int unsigned DEF_LINKUP_DELAY   = 31;     // settling before linkup

endpackage : sata_link_pkg

`default_nettype wire

//--- link_init/sata_rx_prim_detect.sv
// rx_word and sync_status must already be synchronous to tx_reset; flags lag the input by one cycle
`timescale 1ns/100ps
`default_nettype none

module sata_rx_prim_detect (
    input  logic                      tx_reset,     // clock
    input  logic                      tx_clk,       // async reset, active high
    input  sata_prim_pkg::sata_dword_t rx_word,
    input  logic [3:0]                sync_status,  // per-byte word sync
    output logic                      align_seen,
    output logic                      sync_seen,
    output logic                      sync_locked
);
    import sata_prim_pkg::*;

    logic is_align;
    logic is_sync;
    logic all_locked;

    // ------------------------------
    // compare, data and k-flags both
    // ------------------------------
    assign is_align   = (rx_word == ALIGN_DWORD);
    assign is_sync    = (rx_word == SYNC_DWORD);
    assign all_locked = &sync_status;   // every byte lane in sync

    // one register stage for all three flags
    always_ff @(posedge tx_reset or posedge tx_clk) begin
        if (tx_clk) begin
            align_seen  <= 1'b0;
            sync_seen   <= 1'b0;
            sync_locked <= 1'b0;
        end else begin
            align_seen  <= is_align;
            sync_seen   <= is_sync;
            sync_locked <= all_locked;
        end
    end

endmodule : sata_rx_prim_detect

`default_nettype wire

//--- link_init/sata_link_init_fsm.sv
// tx_reset is the clock and tx_clk the async active-high reset; COM answers must be 1-cycle pulses
`timescale 1ns/100ps
`default_nettype none

module sata_link_init_fsm #(
    parameter int unsigned TIMEOUT_CYCLES = sata_link_pkg::DEF_TIMEOUT_CYCLES
) (
    input  logic                      tx_reset,     // clock
    input  logic                      tx_clk,       // async reset, active high
    input  sata_link_pkg::rx_status_t rx_status,
    input  logic                      oob_ready,    // signaller idle, can take a command
    input  logic                      align_seen,
    input  logic                      sync_seen,
    input  logic                      sync_locked,
    output sata_link_pkg::oob_cmd_t   oob_cmd,
    output logic                      dial_sel,
    output logic                      link_ready
);
    import sata_link_pkg::*;

    localparam int unsigned   TW           = $clog2(TIMEOUT_CYCLES + 1);
    localparam logic [TW-1:0] TIMEOUT_LAST = TW'(TIMEOUT_CYCLES);

    link_state_t   state;
    logic [7:0]    state_bits;
    logic          timeout_run;
    logic          timeout_hit;
    logic [TW-1:0] timeout_cnt;

    // ------------------------------
    // outputs straight from state bits
    // ------------------------------
    assign state_bits         = state;
    assign link_ready         = state_bits[BIT_LINK_READY];
    assign oob_cmd.comreset   = state_bits[BIT_COMRESET];
    assign oob_cmd.comwake    = state_bits[BIT_COMWAKE];
    assign oob_cmd.oob_finish = state_bits[BIT_OOB_FINISH];
    assign dial_sel           = state_bits[BIT_DIAL_SEL];
    assign timeout_run        = state_bits[BIT_TIMEOUT_RUN];

    assign timeout_hit = (timeout_cnt == TIMEOUT_LAST);

    // ------------------------------
    // timeout counter
    // ------------------------------
    // wait_comwake..send_align share one budget, bit 5 stays set across them
    always_ff @(posedge tx_reset or posedge tx_clk) begin
        if (tx_clk) begin
            timeout_cnt <= '0;
        end else if (timeout_run) begin
            timeout_cnt <= timeout_cnt + 1'b1;
        end else begin
            timeout_cnt <= '0;
        end
    end

    // ------------------------------
    // state register
    // ------------------------------
    always_ff @(posedge tx_reset or posedge tx_clk) begin
        if (tx_clk) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:
                    if (rx_status.locked_to_ref) state <= st_send_comreset;

                st_send_comreset:
                    state <= st_suspend_comreset;   // single pulse

                st_suspend_comreset:
                    if (oob_ready) state <= st_wait_cominit;

                st_wait_cominit: begin
                    if (rx_status.cominit) begin
                        state <= st_send_comwake;
                    end else if (timeout_hit) begin
                        state <= st_idle;           // no device, retry
                    end
                end

                st_send_comwake:
                    state <= st_suspend_comwake;

                st_suspend_comwake:
                    if (oob_ready) state <= st_wait_comwake;

                st_wait_comwake: begin
                    if (rx_status.comwake) begin
                        state <= st_wait_oobfinish;
                    end else if (timeout_hit) begin
                        state <= st_idle;
                    end
                end

                st_wait_oobfinish: begin
                    if (rx_status.oob_finish) begin
                        state <= st_send_dial;
                    end else if (timeout_hit) begin
                        state <= st_idle;
                    end
                end

                // device must be word-locked when it sends ALIGN back
                st_send_dial: begin
                    if (align_seen && sync_locked) begin
                        state <= st_send_align;
                    end else if (timeout_hit) begin
                        state <= st_idle;
                    end
                end

                st_send_align: begin
                    if (sync_seen) begin
                        state <= st_link_ready;
                    end else if (timeout_hit) begin
                        state <= st_idle;
                    end
                end

                st_link_ready:
                    if (!(rx_status.signal_detect && sync_locked)) state <= st_idle;  // link lost

                default:
                    state <= st_idle;
            endcase
        end
    end

endmodule : sata_link_init_fsm

`default_nettype wire

//--- hdl/sata_tx_word_mux.sv
// ALIGN_INTERVAL must be at least 3; tx_user is taken only while tx_ready is high and must be held
`timescale 1ns/100ps
`default_nettype none

module sata_tx_word_mux #(
    parameter int unsigned ALIGN_INTERVAL = sata_link_pkg::DEF_ALIGN_INTERVAL
) (
    input  logic                       tx_reset,    // clock
    input  logic                       tx_clk,      // async reset, active high
    input  logic                       dial_sel,    // send D10.2
    input  logic                       link_ready,
    input  sata_prim_pkg::sata_dword_t tx_user,
    output sata_prim_pkg::sata_dword_t tx_word,
    output logic                       tx_ready
);
    import sata_prim_pkg::*;

    localparam int unsigned   AW       = $clog2(ALIGN_INTERVAL);
    localparam logic [AW-1:0] CNT_LAST = AW'(ALIGN_INTERVAL - 1);

    logic [AW-1:0] interval_cnt;
    logic          align_slot;   // current cycle is an ALIGN slot
    logic          slot_next;

    // ------------------------------
    // interval counter
    // ------------------------------
    // 0 in the first link_ready cycle, wraps every ALIGN_INTERVAL
    always_ff @(posedge tx_reset or posedge tx_clk) begin
        if (tx_clk) begin
            interval_cnt <= '0;
        end else if (!link_ready) begin
            interval_cnt <= '0;
        end else if (interval_cnt == CNT_LAST) begin
            interval_cnt <= '0;
        end else begin
            interval_cnt <= interval_cnt + 1'b1;
        end
    end

    // two slots per interval, counts 0 and 1
    assign slot_next = link_ready && (interval_cnt == AW'(0) || interval_cnt == AW'(1));

    always_ff @(posedge tx_reset or posedge tx_clk) begin
        if (tx_clk) begin
            align_slot <= 1'b0;
        end else begin
            align_slot <= slot_next;
        end
    end

    assign tx_ready = ~align_slot;   // user held off during ALIGN pair

    // ------------------------------
    // transmit register
    // ------------------------------
    always_ff @(posedge tx_reset or posedge tx_clk) begin
        if (tx_clk) begin
            tx_word <= IDLE_DWORD;
        end else if (dial_sel) begin
            tx_word <= DIAL_DWORD;
        end else if (link_ready && tx_ready) begin
            tx_word <= tx_user;     // user word, one cycle latency
        end else begin
            tx_word <= ALIGN_DWORD; // idle fill and inserted ALIGNs
        end
    end

endmodule : sata_tx_word_mux

`default_nettype wire

//--- hdl/sata_linkup_qualifier.sv
// linkup rises after LINKUP_DELAY+1 link_ready cycles and drops one cycle after link_ready drops
`timescale 1ns/100ps
`default_nettype none

module sata_linkup_qualifier #(
    parameter int unsigned LINKUP_DELAY = sata_link_pkg::DEF_LINKUP_DELAY
) (
    input  logic tx_reset,     // clock
    input  logic tx_clk,       // async reset, active high
    input  logic link_ready,
    output logic linkup
);
    localparam int unsigned   CW        = $clog2(LINKUP_DELAY + 1) > 0 ? $clog2(LINKUP_DELAY + 1) : 1;
    localparam logic [CW-1:0] CNT_LIMIT = CW'(LINKUP_DELAY);

    logic [CW-1:0] ready_cnt;
    logic          cnt_done;

    assign cnt_done = (ready_cnt == CNT_LIMIT);

    // ------------------------------
    // settle counter, saturating
    // ------------------------------
    always_ff @(posedge tx_reset or posedge tx_clk) begin
        if (tx_clk) begin
            ready_cnt <= '0;
        end else if (!link_ready) begin
            ready_cnt <= '0;            // any drop restarts settling
        end else if (!cnt_done) begin
            ready_cnt <= ready_cnt + 1'b1;
        end
    end

    always_ff @(posedge tx_reset or posedge tx_clk) begin
        if (tx_clk) begin
            linkup <= 1'b0;
        end else begin
            linkup <= link_ready && cnt_done;
        end
    end

endmodule : sata_linkup_qualifier

`default_nettype wire

//--- hdl/sata_phy_ctrl.sv
// single domain, tx_reset clocks and tx_clk resets; all rx inputs must be synchronous to tx_reset
`timescale 1ns/100ps
`default_nettype none

module sata_phy_ctrl #(
    parameter int unsigned TIMEOUT_CYCLES = sata_link_pkg::DEF_TIMEOUT_CYCLES,
    parameter int unsigned ALIGN_INTERVAL = sata_link_pkg::DEF_ALIGN_INTERVAL,
    parameter int unsigned LINKUP_DELAY   = sata_link_pkg::DEF_LINKUP_DELAY
) (
    input  logic                       tx_reset,   // clock
    input  logic                       tx_clk,     // async reset, active high
    // receive side, already in this domain
    input  sata_prim_pkg::sata_dword_t rx_word,
    input  sata_link_pkg::rx_status_t  rx_status,
    // oob signaller
    input  logic                       oob_ready,
    output sata_link_pkg::oob_cmd_t    oob_cmd,
    // user transmit
    input  sata_prim_pkg::sata_dword_t tx_user,
    output sata_prim_pkg::sata_dword_t tx_word,
    output logic                       tx_ready,
    output logic                       linkup
);
    logic align_seen;
    logic sync_seen;
    logic sync_locked;
    logic dial_sel;
    logic link_ready;

    // ------------------------------
    // receive primitive flags
    // ------------------------------
    sata_rx_prim_detect u_rx_prim_detect (
        .tx_reset    (tx_reset),
        .tx_clk      (tx_clk),
        .rx_word     (rx_word),
        .sync_status (rx_status.sync_status),
        .align_seen  (align_seen),
        .sync_seen   (sync_seen),
        .sync_locked (sync_locked)
    );

    // oob and primitive handshake
    sata_link_init_fsm #(
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) u_link_init_fsm (
        .tx_reset    (tx_reset),
        .tx_clk      (tx_clk),
        .rx_status   (rx_status),
        .oob_ready   (oob_ready),
        .align_seen  (align_seen),
        .sync_seen   (sync_seen),
        .sync_locked (sync_locked),
        .oob_cmd     (oob_cmd),
        .dial_sel    (dial_sel),
        .link_ready  (link_ready)
    );

    // ------------------------------
    // transmit path
    // ------------------------------
    sata_tx_word_mux #(
        .ALIGN_INTERVAL (ALIGN_INTERVAL)
    ) u_tx_word_mux (
        .tx_reset   (tx_reset),
        .tx_clk     (tx_clk),
        .dial_sel   (dial_sel),
        .link_ready (link_ready),
        .tx_user    (tx_user),
        .tx_word    (tx_word),
        .tx_ready   (tx_ready)
    );

    sata_linkup_qualifier #(
        .LINKUP_DELAY (LINKUP_DELAY)
    ) u_linkup_qualifier (
        .tx_reset   (tx_reset),
        .tx_clk     (tx_clk),
        .link_ready (link_ready),
        .linkup     (linkup)
    );

endmodule : sata_phy_ctrl

`default_nettype wire

//--- dv/sata_tb_clkgen.sv
// free-running clock from time 0; reset is released on a falling edge, away from the sampling edge
`timescale 1ns/100ps
`default_nettype none

module sata_tb_clkgen #(
    parameter int unsigned PERIOD_NS    = 20,
    parameter int unsigned RESET_CYCLES = 16
) (
    output logic tx_reset,   // clock
    output logic tx_clk      // reset, active high
);
    // clock, starts low
    initial begin
        tx_reset = 1'b0;
        forever #(PERIOD_NS / 2) tx_reset = ~tx_reset;
    end

    // reset held for RESET_CYCLES rising edges
    initial begin
        tx_clk = 1'b1;
        repeat (RESET_CYCLES) @(posedge tx_reset);
        @(negedge tx_reset);
        tx_clk = 1'b0;   // mid-cycle release
    end

endmodule : sata_tb_clkgen

`default_nettype wire

//--- dv/sata_phy_ctrl_tb.sv
// inputs change 2 ns after the rising edge and outputs are read there; run ends at RUN_LIMIT cycles
`timescale 1ns/100ps
`default_nettype none

module sata_phy_ctrl_tb;
    import sata_prim_pkg::*;
    import sata_link_pkg::*;

    // ------------------------------
    // DUT setup and run budget
    // ------------------------------
    localparam int unsigned TIMEOUT_CYCLES = 40;
    localparam int unsigned ALIGN_INTERVAL = 16;
    localparam int unsigned LINKUP_DELAY   = 8;
    localparam int unsigned STIM_DELAY     = 2;     // ns after the rising edge
    localparam int unsigned WINDOW         = 4 * ALIGN_INTERVAL;

    // cycles per test, the sum is the hard stop
    localparam int unsigned BUDGET_RESET     = 200;
    localparam int unsigned BUDGET_BRING_UP  = 600;
    localparam int unsigned BUDGET_ALIGN     = 400;
    localparam int unsigned BUDGET_LINK_LOSS = 300;
    localparam int unsigned BUDGET_TIMEOUT   = 500;
    localparam int unsigned RUN_LIMIT = BUDGET_RESET + BUDGET_BRING_UP + BUDGET_ALIGN
                                      + BUDGET_LINK_LOSS + BUDGET_TIMEOUT;

    localparam oob_cmd_t OOB_NONE        = '{comreset: 1'b0, comwake: 1'b0, oob_finish: 1'b0};
    localparam oob_cmd_t WANT_COMRESET   = '{comreset: 1'b1, comwake: 1'b0, oob_finish: 1'b0};
    localparam oob_cmd_t WANT_COMWAKE    = '{comreset: 1'b0, comwake: 1'b1, oob_finish: 1'b0};
    localparam oob_cmd_t WANT_OOB_FINISH = '{comreset: 1'b0, comwake: 1'b0, oob_finish: 1'b1};

    logic        tx_reset;     // clock
    logic        tx_clk;       // reset
    sata_dword_t rx_word;
    rx_status_t  rx_status;
    logic        oob_ready;
    sata_dword_t tx_user;
    sata_dword_t tx_word;
    logic        tx_ready;
    oob_cmd_t    oob_cmd;
    logic        linkup;

    string       test_name;
    int          check_count     = 0;
    int          error_count     = 0;
    int          cycle_count     = 0;
    int          comreset_cycles = 0;   // cycles with comreset high
    logic [31:0] lfsr_state;

    sata_tb_clkgen #(
        .PERIOD_NS    (20),
        .RESET_CYCLES (16)
    ) u_clkgen (
        .tx_reset (tx_reset),
        .tx_clk   (tx_clk)
    );

    sata_phy_ctrl #(
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES),
        .ALIGN_INTERVAL (ALIGN_INTERVAL),
        .LINKUP_DELAY   (LINKUP_DELAY)
    ) u_dut (
        .tx_reset  (tx_reset),
        .tx_clk    (tx_clk),
        .rx_word   (rx_word),
        .rx_status (rx_status),
        .oob_ready (oob_ready),
        .oob_cmd   (oob_cmd),
        .tx_user   (tx_user),
        .tx_word   (tx_word),
        .tx_ready  (tx_ready),
        .linkup    (linkup)
    );

    // ------------------------------
    // watchdog and comreset monitor
    // ------------------------------
    always @(posedge tx_reset) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= RUN_LIMIT) begin
            $display("simulation timed out after %0d cycles", cycle_count);
            $display("checks: %0d  errors: %0d", check_count, error_count);
            $display("Some tests failed");
            $finish;
        end
    end

    always @(negedge tx_reset) begin
        if (oob_cmd.comreset === 1'b1) comreset_cycles = comreset_cycles + 1;   // mid-cycle, stable
    end

    // ------------------------------
    // helpers
    // ------------------------------
    // next rising edge, then the stimulus offset
    task automatic next_cycle();
        @(posedge tx_reset);
        #(STIM_DELAY);
    endtask

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) n = n ^ 32'h8020_0003;
        return n;
    endfunction

    task automatic next_random_dword(output sata_dword_t word);
        logic [31:0] bits;
        int          i;
        bits = '0;
        for (i = 0; i < 32; i++) begin
            bits[i]    = lfsr_state[0];          // one step per bit
            lfsr_state = lfsr_next(lfsr_state);
        end
        word.data  = bits;
        word.datak = 4'b0000;                    // plain data dword
    endtask

    task automatic report_failure(input string msg);
        error_count++;
        $display("%s: %s", test_name, msg);
    endtask

    task automatic check_dword(input string what, input sata_dword_t expected,
                               input sata_dword_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error: %s: %s expected %h/%b actual %h/%b", test_name, what,
                     expected.data, expected.datak, actual.data, actual.datak);
        end
    endtask

    task automatic check_bit(input string what, input logic expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error: %s: %s expected %b actual %b", test_name, what, expected, actual);
        end
    endtask

    task automatic check_oob(input string what, input oob_cmd_t expected, input oob_cmd_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error: %s: %s expected %b actual %b", test_name, what, expected, actual);
        end
    endtask

    // bounded wait for any bit of want on oob_cmd
    task automatic wait_for_oob(input oob_cmd_t want, input int max_cycles, output logic found);
        int n;
        found = 1'b0;
        n     = 0;
        while (!found && n <= max_cycles) begin
            if ((oob_cmd & want) != OOB_NONE) begin
                found = 1'b1;
            end else begin
                next_cycle();
                n++;
            end
        end
    endtask

    // signaller busy sending the burst
    task automatic signaller_busy(input int cycles);
        oob_ready = 1'b0;
        repeat (cycles) next_cycle();
        oob_ready = 1'b1;
    endtask

    // device answer a little after the burst, one-cycle pulse
    task automatic send_com_answer(input logic is_comwake);
        repeat (2) next_cycle();
        if (is_comwake) rx_status.comwake = 1'b1;
        else            rx_status.cominit = 1'b1;
        next_cycle();
        rx_status.comwake = 1'b0;
        rx_status.cominit = 1'b0;
    endtask

    // ------------------------------
    // model device, oob part
    // ------------------------------
    task automatic device_answer_oob(output logic ok);
        logic found;
        ok = 1'b0;
        wait_for_oob(WANT_COMRESET, 20, found);
        if (!found) begin
            report_failure("the DUT sent no comreset");
        end else begin
            signaller_busy(3);
            send_com_answer(1'b0);                  // cominit
            wait_for_oob(WANT_COMWAKE, 20, found);
            if (!found) begin
                report_failure("the DUT sent no comwake after cominit");
            end else begin
                signaller_busy(3);
                send_com_answer(1'b1);              // comwake
                wait_for_oob(WANT_OOB_FINISH, 20, found);
                if (!found) begin
                    report_failure("the DUT never raised oob_finish");
                end else begin
                    check_oob("oob_cmd after comwake", WANT_OOB_FINISH, oob_cmd);
                    rx_status.oob_finish = 1'b1;     // level from here on
                    ok = 1'b1;
                end
            end
        end
    endtask

    // ------------------------------
    // tests
    // ------------------------------
    task automatic check_idle_outputs(input string when);
        check_oob({"oob_cmd ", when}, OOB_NONE, oob_cmd);
        check_bit({"linkup ", when}, 1'b0, linkup);
        check_bit({"tx_ready ", when}, 1'b1, tx_ready);
    endtask

    task automatic test_reset_state();
        test_name = "reset_state";
        repeat (4) begin
            next_cycle();
            check_idle_outputs("in reset");
            check_dword("tx_word in reset", IDLE_DWORD, tx_word);
        end
        @(negedge tx_clk);
        #1;
        check_idle_outputs("at release");
        check_dword("tx_word at release", IDLE_DWORD, tx_word);
        next_cycle();                                // first clock after release
        check_idle_outputs("after release");
        check_dword("tx_word after release", ALIGN_DWORD, tx_word);
    endtask

    task automatic test_bring_up();
        logic ok;
        logic found;
        int   k;
        test_name = "bring_up";
        next_random_dword(tx_user);                  // marker for the first user word
        rx_status.signal_detect = 1'b1;
        rx_status.locked_to_ref = 1'b1;
        rx_status.sync_status   = 4'hF;
        device_answer_oob(ok);
        if (ok) begin
            found = 1'b0;
            for (k = 0; k < 10 && !found; k++) begin
                if (tx_word == DIAL_DWORD) found = 1'b1;
                else next_cycle();
            end
            if (!found) report_failure("tx_word never showed the dial pattern");
            repeat (3) begin                         // no ALIGN yet, dial must go on
                check_dword("tx_word before ALIGN", DIAL_DWORD, tx_word);
                check_bit("linkup in dial", 1'b0, linkup);
                next_cycle();
            end
            rx_word = ALIGN_DWORD;
            found   = 1'b0;
            for (k = 0; k < 10 && !found; k++) begin
                next_cycle();
                if (tx_word == ALIGN_DWORD) found = 1'b1;
                else check_dword("tx_word waiting for ALIGN reply", DIAL_DWORD, tx_word);
            end
            if (!found) report_failure("the DUT never answered ALIGN with ALIGN");
            rx_word = SYNC_DWORD;                    // device saw ALIGN
            found   = 1'b0;
            for (k = 0; k < 10 && !found; k++) begin
                next_cycle();
                check_bit("linkup before data", 1'b0, linkup);
                if (tx_word == tx_user) found = 1'b1;
                else check_dword("tx_word before link ready", ALIGN_DWORD, tx_word);
            end
            if (!found) report_failure("the first user word never reached tx_word");
            // link_ready rose one cycle before the word showed up
            for (k = 1; k <= LINKUP_DELAY; k++) begin
                next_cycle();
                check_bit("linkup settling", (k == LINKUP_DELAY), linkup);
            end
        end
        if (comreset_cycles != 1) begin
            report_failure($sformatf("comreset was high %0d cycles, one pulse expected",
                                     comreset_cycles));
        end
    endtask

    task automatic test_align_insertion();
        logic        prev_ready;
        sata_dword_t prev_word;
        sata_dword_t expected;
        int          low_in_block;
        int          i;
        test_name    = "align_insertion";
        prev_ready   = tx_ready;
        prev_word    = tx_user;
        low_in_block = 0;
        for (i = 0; i < WINDOW; i++) begin
            next_cycle();
            expected = prev_ready ? prev_word : ALIGN_DWORD;
            check_dword("tx_word", expected, tx_word);
            check_bit("linkup", 1'b1, linkup);
            check_oob("oob_cmd", OOB_NONE, oob_cmd);
            if (!tx_ready) low_in_block++;
            if ((i % ALIGN_INTERVAL) == ALIGN_INTERVAL - 1) begin
                if (low_in_block != 2) begin
                    error_count++;
                    $display("error: %s: tx_ready low cycles in block %0d expected 2 actual %0d",
                             test_name, i / ALIGN_INTERVAL, low_in_block);
                end
                low_in_block = 0;
            end
            if (prev_ready) next_random_dword(tx_user);   // last word taken, else hold
            prev_ready = tx_ready;
            prev_word  = tx_user;
        end
    endtask

    task automatic test_link_loss();
        logic fell;
        logic found;
        int   k;
        test_name = "link_loss";
        rx_status.signal_detect = 1'b0;
        rx_status.oob_finish    = 1'b0;
        rx_word = '0;
        fell = 1'b0;
        for (k = 0; k < 3 && !fell; k++) begin
            next_cycle();
            if (!linkup) fell = 1'b1;
        end
        if (!fell) report_failure("linkup stayed high 3 cycles after signal loss");
        wait_for_oob(WANT_COMRESET, 10, found);
        if (!found) report_failure("no new comreset after the link was lost");
    endtask

    // device gone, cominit never comes back
    task automatic test_oob_timeout();
        logic found;
        int   gap;
        test_name = "oob_timeout";
        found = 1'b0;
        gap   = 0;
        while (!found && gap < TIMEOUT_CYCLES + 20) begin
            next_cycle();
            gap++;
            check_bit("linkup", 1'b0, linkup);
            if (oob_cmd.comreset) found = 1'b1;
        end
        if (!found) begin
            report_failure("no second comreset after the cominit timeout");
        end else if (gap < TIMEOUT_CYCLES || gap > TIMEOUT_CYCLES + 8) begin
            error_count++;
            $display("error: %s: comreset gap expected %0d..%0d actual %0d",
                     test_name, TIMEOUT_CYCLES, TIMEOUT_CYCLES + 8, gap);
        end
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        lfsr_state = 32'h0019_8708;
        rx_word    = '0;
        rx_status  = '0;
        oob_ready  = 1'b1;     // signaller idle
        tx_user    = '0;
        test_name  = "init";

        test_reset_state();
        test_bring_up();
        test_align_insertion();
        test_link_loss();
        test_oob_timeout();

        next_cycle();
        $display("checks: %0d  errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule : sata_phy_ctrl_tb

`default_nettype wire

//--- verilog.f
common/sata_prim_pkg.sv
common/sata_link_pkg.sv
link_init/sata_rx_prim_detect.sv
link_init/sata_link_init_fsm.sv
hdl/sata_tx_word_mux.sv
hdl/sata_linkup_qualifier.sv
hdl/sata_phy_ctrl.sv
dv/sata_tb_clkgen.sv
dv/sata_phy_ctrl_tb.sv

//--- Bender.yml
package:
  name: sata_phy_ctrl

sources:
  # shared packages
  - common/sata_prim_pkg.sv
  - common/sata_link_pkg.sv
  # link initialization
  - link_init/sata_rx_prim_detect.sv
  - link_init/sata_link_init_fsm.sv
  # transmit path and top level
  - hdl/sata_tx_word_mux.sv
  - hdl/sata_linkup_qualifier.sv
  - hdl/sata_phy_ctrl.sv
  # testbench
  - target: test
    files:
      - dv/sata_tb_clkgen.sv
      - dv/sata_phy_ctrl_tb.sv
